/* rtl/sramPkg.sv */
package sramPkg;

	//////////////////////////////
	// Array geometry
	//////////////////////////////
	localparam int ADDR_WIDTH = 12;
	localparam int DATA_WIDTH = 16;
	localparam int TAG_WIDTH = 8;
	localparam int MEM_WORDS = 2 ** ADDR_WIDTH;

	//////////////////////////////
	// Buffering and credits
	//////////////////////////////
	// Queue depth doubles as the producer's starting credits
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);
	localparam int RSP_DEPTH = 2;
	localparam int RSP_PTR_WIDTH = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;
	localparam int RSP_CNT_WIDTH = $clog2(RSP_DEPTH + 1);
	localparam int RSP_CREDITS = 2;
	localparam int RSP_CREDIT_WIDTH = $clog2(RSP_CREDITS + 1);

	//////////////////////////////
	// Strobe timing in clocks
	//////////////////////////////
	localparam int WRITE_CYCLES = 2;
	// Address access time of the part, rounded up to whole clocks
	localparam int ACCESS_CYCLES = 3;
	localparam int CYCLE_CNT_WIDTH = 2;

	// Sequencer state codes
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_WRITE = 2'd1;
	localparam logic [1:0] ST_READ = 2'd2;

	// One request word, op bit on top, address in the same place in both views
	typedef union packed {
		struct packed {
			logic op;
			logic [2:0] spare;
			logic [ADDR_WIDTH-1:0] addr;
			logic [DATA_WIDTH-1:0] data;
		} writeView;
		struct packed {
			logic op;
			logic [2:0] spareHigh;
			logic [ADDR_WIDTH-1:0] addr;
			logic [3:0] spareMid;
			logic [TAG_WIDTH-1:0] tag;
			logic [3:0] spareLow;
		} readView;
	} sramReq;

endpackage

/* rtl/sramReqIf.sv */
`timescale 1ns/1ns

// Queue head as seen by the sequencer
interface sramReqIf import sramPkg::*; ();

	logic headValid;
	sramReq headWord;
	// Entry leaves the queue on the edge where pop is high
	logic pop;

	modport source (
		output headValid,
		output headWord,
		input pop
	);

	modport sink (
		input headValid,
		input headWord,
		output pop
	);

endinterface

/* rtl/sramBusIf.sv */
`timescale 1ns/1ns

// SRAM pins, data in and data out kept apart
interface sramBusIf import sramPkg::*; ();

	logic chipEnable;
	logic outputEnable;
	logic writeEnable;
	logic [ADDR_WIDTH-1:0] addr;
	logic [DATA_WIDTH-1:0] writeData;
	logic [DATA_WIDTH-1:0] readData;

	modport master (
		output chipEnable, outputEnable, writeEnable,
		output addr, writeData,
		input readData
	);

	modport slave (
		input chipEnable, outputEnable, writeEnable,
		input addr, writeData,
		output readData
	);

endinterface

/* rtl/requestQueue.sv */
`timescale 1ns/1ns

module requestQueue import sramPkg::*; (
	input logic clk,
	input logic reset,
	input logic reqValid,
	input sramReq reqWord,
	output logic reqCredit,
	sramReqIf.source head
);

	// Request storage, payload only
	sramReq entries [QUEUE_DEPTH];
	logic [QUEUE_PTR_WIDTH-1:0] wrPtr;
	logic [QUEUE_PTR_WIDTH-1:0] rdPtr;
	logic [QUEUE_CNT_WIDTH-1:0] fillCount;
	logic push;
	logic popDone;

	// Producer only sends on a credit, full guard is a safety net
	assign push = reqValid && (fillCount != QUEUE_CNT_WIDTH'(QUEUE_DEPTH));
	assign popDone = head.pop && head.headValid;

	// Oldest word straight out of the buffer
	assign head.headValid = (fillCount != '0);
	assign head.headWord = entries[rdPtr];

	//////////////////////////////
	// Storage write
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (push) begin
			entries[wrPtr] <= reqWord;
		end
	end

	//////////////////////////////
	// Pointers, count, credit
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fillCount <= '0;
			reqCredit <= 1'b0;
		end else begin
			if (push) begin
				// Wrap at the last entry
				wrPtr <= (wrPtr == QUEUE_PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (popDone) begin
				rdPtr <= (rdPtr == QUEUE_PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			// Count tracks push and pop in the same cycle
			case ({push, popDone})
				2'b10: fillCount <= fillCount + 1'b1;
				2'b01: fillCount <= fillCount - 1'b1;
				default: fillCount <= fillCount;
			endcase
			// One credit back per freed entry
			reqCredit <= popDone;
		end
	end

endmodule

/* rtl/sramSequencer.sv */
`timescale 1ns/1ns

module sramSequencer import sramPkg::*; (
	input logic clk,
	input logic reset,
	sramReqIf.sink head,
	sramBusIf.master bus,
	input logic spaceFree,
	output logic resultValid,
	output logic [DATA_WIDTH-1:0] resultData,
	output logic [TAG_WIDTH-1:0] resultTag
);

	logic [1:0] state;
	logic [CYCLE_CNT_WIDTH-1:0] cycleCnt;
	logic [ADDR_WIDTH-1:0] addrReg;
	logic [DATA_WIDTH-1:0] dataReg;
	logic isWrite;
	logic startOp;
	logic lastWrite;
	logic lastRead;

	//////////////////////////////
	// Head decode
	//////////////////////////////
	assign isWrite = head.headWord.writeView.op;
	// Reads wait for room on the output side
	assign startOp = head.headValid && (isWrite || spaceFree);
	assign lastWrite = (state == ST_WRITE) && (cycleCnt == CYCLE_CNT_WIDTH'(WRITE_CYCLES - 1));
	assign lastRead = (state == ST_READ) && (cycleCnt == CYCLE_CNT_WIDTH'(ACCESS_CYCLES - 1));

	// Pop in the first strobe cycle
	assign head.pop = (state != ST_IDLE) && (cycleCnt == '0);

	// Strobes straight from the state register
	assign bus.chipEnable = (state != ST_IDLE);
	assign bus.writeEnable = (state == ST_WRITE);
	assign bus.outputEnable = (state == ST_READ);
	assign bus.addr = addrReg;
	assign bus.writeData = dataReg;

	//////////////////////////////
	// State and cycle counter
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			cycleCnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					cycleCnt <= '0;
					if (startOp) begin
						state <= isWrite ? ST_WRITE : ST_READ;
					end
				end
				ST_WRITE, ST_READ: begin
					// Back to idle gives the one quiet cycle between requests
					if (lastWrite || lastRead) begin
						state <= ST_IDLE;
						cycleCnt <= '0;
					end else begin
						cycleCnt <= cycleCnt + 1'b1;
					end
				end
				default: begin
					state <= ST_IDLE;
					cycleCnt <= '0;
				end
			endcase
		end
	end

	//////////////////////////////
	// Payload capture
	//////////////////////////////
	always_ff @(posedge clk) begin
		if ((state == ST_IDLE) && startOp) begin
			// Address sits in the same bits in both views
			addrReg <= head.headWord.writeView.addr;
			dataReg <= head.headWord.writeView.data;
		end
		// Tag held from pop until the result goes out
		if (head.pop && (state == ST_READ)) begin
			resultTag <= head.headWord.readView.tag;
		end
		// Data sampled in the last access cycle
		if (lastRead) begin
			resultData <= bus.readData;
		end
	end

	// Result pulse on the edge after the last access cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			resultValid <= 1'b0;
		end else begin
			resultValid <= lastRead;
		end
	end

endmodule

/* rtl/sramArray.sv */
`timescale 1ns/1ns

module sramArray import sramPkg::*; (
	input logic clk,
	sramBusIf.slave bus
);

	logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
	// Previous consecutive read cycles, saturating
	logic [CYCLE_CNT_WIDTH-1:0] accessCnt;
	logic readStrobe;
	logic dataValid;

	assign readStrobe = bus.chipEnable && bus.outputEnable && !bus.writeEnable;
	// Count including this cycle reaches the access time
	assign dataValid = readStrobe && (accessCnt == CYCLE_CNT_WIDTH'(ACCESS_CYCLES - 1));

	// Write on the edge while CE and WE are high
	always_ff @(posedge clk) begin
		if (bus.chipEnable && bus.writeEnable) begin
			mem[bus.addr] <= bus.writeData;
		end
	end

	// Access timer restarts whenever the read strobes drop
	always_ff @(posedge clk) begin
		if (!readStrobe) begin
			accessCnt <= '0;
		end else if (!dataValid) begin
			accessCnt <= accessCnt + 1'b1;
		end
	end

	// Zero until the access time has passed
	assign bus.readData = dataValid ? mem[bus.addr] : '0;

endmodule

/* rtl/readReturn.sv */
`timescale 1ns/1ns

module readReturn import sramPkg::*; (
	input logic clk,
	input logic reset,
	input logic resultValid,
	input logic [DATA_WIDTH-1:0] resultData,
	input logic [TAG_WIDTH-1:0] resultTag,
	output logic spaceFree,
	input logic rspCredit,
	output logic rspValid,
	output logic [DATA_WIDTH-1:0] rspData,
	output logic [TAG_WIDTH-1:0] rspTag
);

	logic [DATA_WIDTH-1:0] dataBuf [RSP_DEPTH];
	logic [TAG_WIDTH-1:0] tagBuf [RSP_DEPTH];
	logic [RSP_PTR_WIDTH-1:0] wrPtr;
	logic [RSP_PTR_WIDTH-1:0] rdPtr;
	logic [RSP_CNT_WIDTH-1:0] fillCount;
	// Consumer credits on hand
	logic [RSP_CREDIT_WIDTH-1:0] creditCount;
	logic send;

	assign send = (fillCount != '0) && (creditCount != '0);
	// A result landing this cycle already owns a slot
	assign spaceFree = (fillCount + RSP_CNT_WIDTH'(resultValid)) < RSP_CNT_WIDTH'(RSP_DEPTH);

	// Result slots hold payload only
	always_ff @(posedge clk) begin
		if (resultValid) begin
			dataBuf[wrPtr] <= resultData;
			tagBuf[wrPtr] <= resultTag;
		end
		if (send) begin
			rspData <= dataBuf[rdPtr];
			rspTag <= tagBuf[rdPtr];
		end
	end

	//////////////////////////////
	// Pointers, fill, credits
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fillCount <= '0;
			creditCount <= RSP_CREDIT_WIDTH'(RSP_CREDITS);
			rspValid <= 1'b0;
		end else begin
			if (resultValid) begin
				wrPtr <= (wrPtr == RSP_PTR_WIDTH'(RSP_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (send) begin
				rdPtr <= (rdPtr == RSP_PTR_WIDTH'(RSP_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({resultValid, send})
				2'b10: fillCount <= fillCount + 1'b1;
				2'b01: fillCount <= fillCount - 1'b1;
				default: fillCount <= fillCount;
			endcase
			// Spend one per response and gain one per returned pulse
			case ({send, rspCredit})
				2'b10: creditCount <= creditCount - 1'b1;
				2'b01: creditCount <= creditCount + 1'b1;
				default: creditCount <= creditCount;
			endcase
			rspValid <= send;
		end
	end

endmodule

/* rtl/sramSubsystem.sv */
`timescale 1ns/1ns

module sramSubsystem import sramPkg::*; (
	input logic clk,
	input logic reset,
	input logic reqValid,
	input sramReq reqWord,
	output logic reqCredit,
	input logic rspCredit,
	output logic rspValid,
	output logic [DATA_WIDTH-1:0] rspData,
	output logic [TAG_WIDTH-1:0] rspTag
);

	//////////////////////////////
	// Internal links
	//////////////////////////////
	sramReqIf reqLink ();
	sramBusIf sramBus ();

	// Sequencer to output side
	logic resultValid;
	logic [DATA_WIDTH-1:0] resultData;
	logic [TAG_WIDTH-1:0] resultTag;
	logic spaceFree;

	requestQueue u_requestQueue (
		.clk(clk),
		.reset(reset),
		.reqValid(reqValid),
		.reqWord(reqWord),
		.reqCredit(reqCredit),
		.head(reqLink.source)
	);

	sramSequencer u_sramSequencer (
		.clk(clk),
		.reset(reset),
		.head(reqLink.sink),
		.bus(sramBus.master),
		.spaceFree(spaceFree),
		.resultValid(resultValid),
		.resultData(resultData),
		.resultTag(resultTag)
	);

	sramArray u_sramArray (
		.clk(clk),
		.bus(sramBus.slave)
	);

	readReturn u_readReturn (
		.clk(clk),
		.reset(reset),
		.resultValid(resultValid),
		.resultData(resultData),
		.resultTag(resultTag),
		.spaceFree(spaceFree),
		.rspCredit(rspCredit),
		.rspValid(rspValid),
		.rspData(rspData),
		.rspTag(rspTag)
	);

endmodule

/* tb/sramSubsystem_checker.sv */
`timescale 1ns/1ns

module sramSubsystemChecker import sramPkg::*; (
	input logic clk,
	input logic reset,
	input logic chipEnable,
	input logic outputEnable,
	input logic writeEnable,
	input logic rspValid,
	input logic [RSP_CREDIT_WIDTH-1:0] creditCount
);

	//////////////////////////////
	// SRAM strobes
	//////////////////////////////
	// Read and write never overlap
	strobesExclusive: assert property (@(posedge clk) disable iff (reset)
		!(writeEnable && outputEnable))
		else $error("writeEnable and outputEnable high in the same cycle");

	// OE or WE only inside a chip enable
	strobeNeedsChip: assert property (@(posedge clk) disable iff (reset)
		(writeEnable || outputEnable) |-> chipEnable)
		else $error("strobe high without chipEnable");

	//////////////////////////////
	// Consumer credits
	//////////////////////////////
	// Response sent the cycle before, credit must have been on hand then
	rspOnCredit: assert property (@(posedge clk) disable iff (reset)
		rspValid |-> ($past(creditCount) != '0))
		else $error("response sent with no consumer credit");

	creditBounded: assert property (@(posedge clk) disable iff (reset)
		creditCount <= RSP_CREDIT_WIDTH'(RSP_CREDITS))
		else $error("consumer credit count above its starting value");

endmodule

/* tb/sramSubsystemTb.sv */
`timescale 1ns/1ns

module sramSubsystemTb import sramPkg::*; ();

	logic clk;
	logic reset = 1'b1;
	logic reqValid = 1'b0;
	sramReq reqWord = '0;
	logic rspCredit = 1'b0;
	logic reqCredit;
	logic rspValid;
	logic [DATA_WIDTH-1:0] rspData;
	logic [TAG_WIDTH-1:0] rspTag;

	// One record per line with op, address, value and expected read data
	logic [47:0] opTable [64];
	// Expected {tag, data} in read order
	logic [23:0] expQ [$];
	int errors = 0;
	int timeouts = 0;
	int sent = 0;
	int readsSent = 0;
	int creditPulses = 0;
	int rspCount = 0;
	int heldRsp = 0;
	int cycle = 0;
	int holdFrom = -1;
	int holdCycles = 40;
	int waitLimit = 300;
	int seed = 77;
	int owed = 0;
	int returnDelay = 0;
	logic holding;

	sramSubsystem u_sramSubsystem (
		.clk(clk),
		.reset(reset),
		.reqValid(reqValid),
		.reqWord(reqWord),
		.reqCredit(reqCredit),
		.rspCredit(rspCredit),
		.rspValid(rspValid),
		.rspData(rspData),
		.rspTag(rspTag)
	);

	// Strobe rules bound into the sequencer
	bind sramSequencer sramSubsystemChecker strobeCheck (
		.clk(clk),
		.reset(reset),
		.chipEnable(bus.chipEnable),
		.outputEnable(bus.outputEnable),
		.writeEnable(bus.writeEnable),
		.rspValid(1'b0),
		.creditCount('0)
	);
	// Credit rules bound into the return side
	bind readReturn sramSubsystemChecker creditCheck (
		.clk(clk),
		.reset(reset),
		.chipEnable(1'b0),
		.outputEnable(1'b0),
		.writeEnable(1'b0),
		.rspValid(rspValid),
		.creditCount(creditCount)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic compareValue(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			errors++;
			$display("Error at %0t ns: %s got %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	// Consumer credits frozen for a window of cycles
	assign holding = (holdFrom >= 0) && (cycle >= holdFrom) && (cycle < holdFrom + holdCycles);

	//////////////////////////////
	// Response monitor
	//////////////////////////////
	always @(posedge clk) begin : monitor
		logic [23:0] expected;
		cycle <= cycle + 1;
		if (!reset) begin
			if (reqCredit) begin
				creditPulses <= creditPulses + 1;
			end
			if (rspValid) begin
				rspCount++;
				if (holding) begin
					heldRsp++;
				end
				if (expQ.size() == 0) begin
					errors++;
					$display("Response arrived at %0t ns with no read waiting for it", $time);
				end else begin
					expected = expQ.pop_front();
					compareValue("response data", 32'(rspData), 32'(expected[15:0]));
					compareValue("response tag", 32'(rspTag), 32'(expected[23:16]));
				end
			end
		end
	end

	// Consumer gives each credit back after 0 to 5 cycles
	always @(posedge clk) begin
		if (!reset) begin
			rspCredit <= 1'b0;
			if (rspValid) begin
				owed++;
			end
			if (!holding && owed > 0) begin
				if (returnDelay == 0) begin
					rspCredit <= 1'b1;
					owed--;
					returnDelay = ($random(seed) & 32'h7fff_ffff) % 6;
				end else begin
					returnDelay--;
				end
			end
		end
	end

	//////////////////////////////
	// Producer
	//////////////////////////////
	initial begin
		logic [47:0] rec;
		sramReq word;
		int idx;
		int waitCnt;
		bit done;
		// Unused entries carry op F and end the list
		for (idx = 0; idx < 64; idx++) begin
			opTable[idx] = {4'hF, 44'(idx)};
		end
		$readmemh("tb/sram_input.txt", opTable);
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		// Quiet outputs before any traffic
		repeat (3) begin
			@(posedge clk);
			compareValue("reqCredit after reset", 32'(reqCredit), 32'd0);
			compareValue("rspValid after reset", 32'(rspValid), 32'd0);
		end
		idx = 0;
		done = 1'b0;
		while (!done && idx < 64) begin
			rec = opTable[idx];
			idx++;
			if (rec[47:44] == 4'h2) begin
				holdFrom <= cycle;
			end else if (rec[47:44] > 4'h2) begin
				done = 1'b1;
			end else begin
				@(posedge clk);
				reqValid <= 1'b0;
				waitCnt = 0;
				while (sent - creditPulses >= QUEUE_DEPTH && waitCnt < waitLimit) begin
					@(posedge clk);
					waitCnt++;
				end
				if (waitCnt >= waitLimit) begin
					timeouts++;
					$display("Timeout: no request credit came back within %0d cycles", waitLimit);
					done = 1'b1;
				end else begin
					word = '0;
					if (rec[47:44] == 4'h1) begin
						word.writeView.op = 1'b1;
						word.writeView.addr = rec[43:32];
						word.writeView.data = rec[31:16];
					end else begin
						word.readView.addr = rec[43:32];
						word.readView.tag = rec[23:16];
						expQ.push_back({rec[23:16], rec[15:0]});
						readsSent++;
					end
					reqValid <= 1'b1;
					reqWord <= word;
					sent++;
					// DUT never hands back more credits than requests it took
					compareValue("request credits within requests sent",
						32'(creditPulses <= sent), 32'd1);
				end
			end
		end
		@(posedge clk);
		reqValid <= 1'b0;
		// Drain until every read is answered and every credit is back
		waitCnt = 0;
		while ((expQ.size() != 0 || creditPulses != sent) && waitCnt < waitLimit) begin
			@(posedge clk);
			waitCnt++;
		end
		if (waitCnt >= waitLimit) begin
			timeouts++;
			$display("Timeout: responses or request credits still missing after %0d cycles",
				waitLimit);
		end
		compareValue("request credits returned", 32'(creditPulses), 32'(sent));
		compareValue("responses received", 32'(rspCount), 32'(readsSent));
		compareValue("responses during credit hold", 32'(heldRsp <= RSP_CREDITS), 32'd1);
		$display("Summary: %0d mismatches, %0d timeouts, %0d requests, %0d responses",
			errors, timeouts, sent, rspCount);
		if (errors == 0 && timeouts == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* tb/sram_input.txt */
// op_addr_value_expect: op 1 write (value is data), op 0 read (value is tag, expect is data)
// op 2 starts the consumer credit hold, op 3 ends the list
1_000_1111_0000
0_000_0001_1111
1_ABC_BEEF_0000
0_ABC_0002_BEEF
1_000_2222_0000
1_FFF_CAFE_0000
0_000_0003_2222
1_123_0F0F_0000
0_FFF_0004_CAFE
1_456_A5A5_0000
2_000_0000_0000
0_123_0005_0F0F
1_789_5A5A_0000
0_456_0006_A5A5
1_ABC_1357_0000
0_789_0007_5A5A
1_321_2468_0000
0_ABC_0008_1357
1_FFF_9999_0000
0_321_0009_2468
1_000_7777_0000
0_FFF_000A_9999
1_555_4242_0000
0_000_000B_7777
3_000_0000_0000

/* flist.f */
rtl/sramPkg.sv
rtl/sramReqIf.sv
rtl/sramBusIf.sv
rtl/requestQueue.sv
rtl/sramSequencer.sv
rtl/sramArray.sv
rtl/readReturn.sv
rtl/sramSubsystem.sv
tb/sramSubsystem_checker.sv
tb/sramSubsystemTb.sv

/* run.sh */
#!/bin/sh
# Build and run the SRAM subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module sramSubsystemTb -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qxF ">>> PASS"; then
	exit 0
fi
echo "Simulation did not report success"
exit 1
